// ==== tb.f ====
verilog/alpha_pkg.sv
verilog/alpha_word_if.sv
verilog/bias_programmer.sv
verilog/alpha_readout.sv
verilog/event_packer.sv
verilog/alpha_eval_core.sv
testbench/tb_alpha_checker.sv
testbench/tb_alpha_assert.sv
testbench/tb_alpha.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_alpha
RTL_TOP   ?= alpha_eval_core
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "Test failed" $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_alpha.sv ====
`timescale 1ns/1ps

module tb_alpha;
	import alpha_pkg::*;

	logic        sysclk;
	logic        reset;
	logic        data_a;
	logic        cfg_valid;
	logic        cfg_ready;
	logic [11:0] cmp_bias;
	logic [11:0] isel;
	logic [11:0] sb_bias;
	logic [11:0] db_bias;
	logic        sin;
	logic        sclk;
	logic        pclk;
	logic        config_done;
	logic        out_valid;
	logic        out_ready;
	logic [3:0]  out_channel;
	logic [4:0]  out_window;
	logic [3:0]  out_index;
	logic [11:0] out_adc;
	logic        out_last;
	logic [7:0]  seq_error_count;
	logic [7:0]  drop_count;

	logic [31:0] rng_state;
	logic [31:0] stall_word;
	logic        random_stall;
	logic        ready_level;
	logic [3:0]  cur_ch;   // header of the packet being sent
	logic [4:0]  cur_win;
	logic [2:0]  cur_cnt;
	int          tests_run;
	int          errors_before;

	alpha_eval_core uut (.*);

	tb_alpha_checker chk (.*);

	initial begin
		sysclk = 1'b0;
		forever #50 sysclk = ~sysclk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// random stall pattern with about three ready cycles in four
	always @(posedge sysclk) begin
		if (random_stall) begin
			stall_word = next_rand();
		end
	end

	always @(negedge sysclk) begin
		if (random_stall) begin
			out_ready <= stall_word[0] | stall_word[1];
		end else begin
			out_ready <= ready_level;
		end
	end

	task automatic abort_run(input string reason);
		$display("timeout: %s", reason);
		$display("Test failed");
		$finish;
	endtask

	// ----------------------------------------
	// serial readout driver
	task automatic send_bit(input logic b);
		@(negedge sysclk);
		data_a = b;
	endtask

	task automatic send_word(input logic [15:0] w, input logic stop_bit);
		send_bit(1'b1);
		for (int i = 15; i >= 0; i--) send_bit(w[i]);
		send_bit(stop_bit);
		send_bit(1'b0); // idle gap
	endtask

	task automatic send_header(input logic [2:0] count);
		logic [31:0] r;
		r = next_rand();
		cur_ch  = r[3:0];
		cur_win = r[8:4];
		cur_cnt = count;
		send_word({4'ha, cur_ch, cur_win, cur_cnt}, 1'b0);
	endtask

	task automatic send_sample(input logic [3:0] idx, input logic stop_bit, input bit forward);
		logic [31:0] r;
		r = next_rand();
		send_word({idx, r[11:0]}, stop_bit);
		if (forward) chk.expect_sample(cur_ch, cur_win, cur_cnt, idx, r[11:0]);
	endtask

	task automatic send_packet(input logic [2:0] count, input bit forward);
		send_header(count);
		for (int i = 0; i <= count; i++) send_sample(4'(i), 1'b0, forward);
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		repeat (30) @(negedge sysclk); // last strobe reaches the ports
		while (chk.pending() != 0 || out_valid) begin
			@(negedge sysclk);
			cycles++;
			if (cycles > 5000) abort_run("output queue did not drain");
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (chk.errors == errors_before) $display("test %s: ok", name);
		else $display("test %s: %0d errors", name, chk.errors - errors_before);
	endtask

	// ----------------------------------------
	task automatic pre_config_drops();
		logic [7:0] drops0;
		logic [31:0] r;
		int sent;
		chk.set_test("pre_config");
		errors_before = chk.errors;
		drops0 = drop_count;
		sent = 0;
		for (int p = 0; p < 2; p++) begin
			r = next_rand();
			send_packet(r[2:0], 1'b0);
			sent += r[2:0] + 1;
		end
		wait_drain();
		chk.check_value("drop_count", 64'(drops0 + sent), 64'(drop_count));
		chk.check_value("seq_error_count", 0, 64'(seq_error_count));
		finish_test("pre_config");
	endtask

	task automatic bias_load();
		logic [31:0] r;
		int cycles;
		chk.set_test("bias_load");
		errors_before = chk.errors;
		r = next_rand();
		cmp_bias = r[11:0];
		isel = r[23:12];
		r = next_rand();
		sb_bias = r[11:0];
		db_bias = r[23:12];
		cycles = 0;
		while (!cfg_ready) begin
			@(negedge sysclk);
			cycles++;
			if (cycles > 1000) abort_run("cfg_ready never came high");
		end
		chk.check_value("config_done before load", 0, 64'(config_done));
		chk.clear_bias();
		@(negedge sysclk);
		cfg_valid = 1'b1;
		@(negedge sysclk); // accepted on the edge in between
		cfg_valid = 1'b0;
		cycles = 0;
		while (!cfg_ready) begin
			@(negedge sysclk);
			cycles++;
			if (cycles > 1000) abort_run("bias load did not finish");
		end
		chk.check_value("load cycles", BIAS_LOAD_CYCLES, cycles);
		chk.check_value("sin bits", {16'h0, cmp_bias, isel, sb_bias, db_bias}, chk.sin_bits);
		chk.check_value("sclk rises", 48, chk.sin_count);
		chk.check_value("pclk pulses", 1, chk.pclk_pulses);
		chk.check_value("config_done", 1, 64'(config_done));
		finish_test("bias_load");
	endtask

	task automatic packet_stream();
		logic [7:0] errs0;
		logic [7:0] drops0;
		logic [31:0] r;
		chk.set_test("stream");
		errors_before = chk.errors;
		errs0 = seq_error_count;
		drops0 = drop_count;
		random_stall <= 1'b1;
		for (int p = 0; p < 6; p++) begin
			r = next_rand();
			send_packet(r[2:0], 1'b1);
		end
		wait_drain();
		random_stall <= 1'b0;
		chk.check_value("seq_error_count", 64'(errs0), 64'(seq_error_count));
		chk.check_value("drop_count", 64'(drops0), 64'(drop_count));
		finish_test("stream");
	endtask

	task automatic sequence_faults();
		logic [7:0] errs0;
		logic [7:0] drops0;
		chk.set_test("faults");
		errors_before = chk.errors;
		errs0 = seq_error_count;
		drops0 = drop_count;
		// wrong index
		send_header(3'd3);
		send_sample(4'd0, 1'b0, 1'b1);
		send_sample(4'd1, 1'b0, 1'b1);
		send_sample(4'd3, 1'b0, 1'b0);
		// bad stop bit
		send_header(3'd3);
		send_sample(4'd0, 1'b0, 1'b1);
		send_sample(4'd1, 1'b0, 1'b1);
		send_sample(4'd2, 1'b1, 1'b0);
		// orphan sample
		send_sample(4'd0, 1'b0, 1'b0);
		// header mid-packet then a whole new packet
		send_header(3'd3);
		send_sample(4'd0, 1'b0, 1'b1);
		send_sample(4'd1, 1'b0, 1'b1);
		send_packet(3'd2, 1'b1);
		wait_drain();
		chk.check_value("seq_error_count", 64'(errs0 + 4), 64'(seq_error_count));
		chk.check_value("drop_count", 64'(drops0), 64'(drop_count));
		finish_test("faults");
	endtask

	task automatic fifo_overflow();
		logic [7:0] drops0;
		chk.set_test("overflow");
		errors_before = chk.errors;
		drops0 = drop_count;
		ready_level <= 1'b0;
		send_packet(3'd7, 1'b1);
		send_packet(3'd7, 1'b0);
		repeat (30) @(negedge sysclk);
		chk.check_value("drop_count", 64'(drops0 + 8), 64'(drop_count));
		ready_level <= 1'b1;
		wait_drain();
		finish_test("overflow");
	endtask

	// ----------------------------------------
	initial begin
		reset = 1'b1;
		data_a = 1'b0;
		cfg_valid = 1'b0;
		cmp_bias = '0;
		isel = '0;
		sb_bias = '0;
		db_bias = '0;
		out_ready = 1'b1;
		random_stall = 1'b0;
		ready_level = 1'b1;
		stall_word = '0;
		rng_state = 32'hfae5_98a3;
		tests_run = 0;
		repeat (10) @(negedge sysclk);
		reset = 1'b0;
		pre_config_drops();
		bias_load();
		packet_stream();
		sequence_faults();
		fifo_overflow();
		$display("tests run %0d, checks failed %0d", tests_run, chk.errors);
		if (chk.errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== testbench/tb_alpha_assert.sv ====
`timescale 1ns/1ps

module tb_alpha_assert (
	input logic        sysclk,
	input logic        reset,
	input logic        cfg_valid,
	input logic        cfg_ready,
	input logic        sclk,
	input logic        pclk,
	input logic        out_valid,
	input logic        out_ready,
	input logic [3:0]  out_channel,
	input logic [4:0]  out_window,
	input logic [3:0]  out_index,
	input logic [11:0] out_adc,
	input logic        out_last
);
	import alpha_pkg::*;

	logic [7:0] load_cnt; // cycles since cfg acceptance

	always_ff @(posedge sysclk) begin
		if (reset) begin
			load_cnt <= '0;
		end else if (cfg_valid && cfg_ready) begin
			load_cnt <= 8'd1;
		end else if (load_cnt != 0 && load_cnt < BIAS_LOAD_CYCLES) begin
			load_cnt <= load_cnt + 1'b1;
		end else begin
			load_cnt <= '0;
		end
	end

	payload_stable: assert property (@(posedge sysclk) disable iff (reset)
		out_valid && !out_ready |=> out_valid
			&& $stable({out_channel, out_window, out_index, out_adc, out_last}))
		else $error("output payload changed while stalled");

	clocks_apart: assert property (@(posedge sysclk) disable iff (reset) !(sclk && pclk))
		else $error("sclk and pclk high together");

	// low on every edge up to and including the last load cycle
	load_busy: assert property (@(posedge sysclk) disable iff (reset)
		(load_cnt != 0) |-> !cfg_ready)
		else $error("cfg_ready returned early");

	load_end: assert property (@(posedge sysclk) disable iff (reset)
		(load_cnt == BIAS_LOAD_CYCLES) |=> cfg_ready)
		else $error("cfg_ready late after bias load");

endmodule

bind alpha_eval_core tb_alpha_assert u_assert (.*);

// ==== testbench/tb_alpha_checker.sv ====
`timescale 1ns/1ps

module tb_alpha_checker (
	input logic        sysclk,
	input logic        sin,
	input logic        sclk,
	input logic        pclk,
	input logic        out_valid,
	input logic        out_ready,
	input logic [3:0]  out_channel,
	input logic [4:0]  out_window,
	input logic [3:0]  out_index,
	input logic [11:0] out_adc,
	input logic        out_last
);

	logic [25:0] exp_q [$];
	logic [25:0] got;
	logic [25:0] want;
	logic [63:0] sin_bits;
	int          sin_count;
	int          pclk_pulses;
	int          errors;
	string       test_name;

	initial begin
		errors      = 0;
		test_name   = "reset";
		sin_bits    = '0;
		sin_count   = 0;
		pclk_pulses = 0;
	end

	// one output entry of a sent packet: header fields, sample fields, last flag
	function automatic logic [25:0] ref_entry(input logic [3:0] ch, input logic [4:0] win,
		input logic [2:0] count, input logic [3:0] idx, input logic [11:0] adc);
		logic last;
		last = idx == {1'b0, count}; // packet carries count+1 samples
		return {ch, win, idx, adc, last};
	endfunction

	task automatic expect_sample(input logic [3:0] ch, input logic [4:0] win,
		input logic [2:0] count, input logic [3:0] idx, input logic [11:0] adc);
		exp_q.push_back(ref_entry(ch, win, count, idx, adc));
	endtask

	function automatic int pending();
		return exp_q.size();
	endfunction

	task automatic set_test(input string name);
		test_name = name;
	endtask

	task automatic clear_bias();
		sin_bits    = '0;
		sin_count   = 0;
		pclk_pulses = 0;
	endtask

	task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			errors++;
			$display("Mismatch %s %s expected %0h actual %0h", test_name, what, exp, act);
		end
	endtask

	// ----------------------------------------
	// output handshake
	always @(posedge sysclk) begin
		if (out_valid && out_ready) begin
			got = {out_channel, out_window, out_index, out_adc, out_last};
			if (exp_q.size() == 0) begin
				errors++;
				$display("%s: an output sample appeared when none was expected", test_name);
			end else begin
				want = exp_q.pop_front();
				check_value("output entry", 64'(want), 64'(got));
			end
		end
	end

	// the chip takes sin on the sclk rise
	always @(posedge sclk) begin
		sin_bits = {sin_bits[62:0], sin};
		sin_count++;
	end

	always @(posedge pclk) pclk_pulses++;

endmodule

// ==== verilog/alpha_eval_core.sv ====
`timescale 1ns/1ps

module alpha_eval_core (
	input  logic                               sysclk,
	input  logic                               reset,
	input  logic                               data_a,
	input  logic                               cfg_valid,
	output logic                               cfg_ready,
	input  logic [alpha_pkg::BIAS_BITS-1:0]    cmp_bias,
	input  logic [alpha_pkg::BIAS_BITS-1:0]    isel,
	input  logic [alpha_pkg::BIAS_BITS-1:0]    sb_bias,
	input  logic [alpha_pkg::BIAS_BITS-1:0]    db_bias,
	output logic                               sin,
	output logic                               sclk,
	output logic                               pclk,
	output logic                               config_done,
	output logic                               out_valid,
	input  logic                               out_ready,
	output logic [alpha_pkg::CHANNEL_BITS-1:0] out_channel,
	output logic [alpha_pkg::WINDOW_BITS-1:0]  out_window,
	output logic [alpha_pkg::INDEX_BITS-1:0]   out_index,
	output logic [alpha_pkg::ADC_BITS-1:0]     out_adc,
	output logic                               out_last,
	output logic [alpha_pkg::COUNT_BITS-1:0]   seq_error_count,
	output logic [alpha_pkg::COUNT_BITS-1:0]   drop_count
);

	alpha_word_if word_bus ();

	// ----------------------------------------
	// bias load port
	bias_programmer u_bias (
		.sysclk      (sysclk),
		.reset       (reset),
		.cfg_valid   (cfg_valid),
		.cfg_ready   (cfg_ready),
		.cmp_bias    (cmp_bias),
		.isel        (isel),
		.sb_bias     (sb_bias),
		.db_bias     (db_bias),
		.sin         (sin),
		.sclk        (sclk),
		.pclk        (pclk),
		.config_done (config_done)
	);

	// ----------------------------------------
	// readout line to tagged samples
	alpha_readout u_readout (
		.sysclk (sysclk),
		.reset  (reset),
		.data_a (data_a),
		.wo     (word_bus.src)
	);

	event_packer u_packer (
		.sysclk          (sysclk),
		.reset           (reset),
		.wi              (word_bus.dst),
		.config_done     (config_done), // gates forwarding
		.out_valid       (out_valid),
		.out_ready       (out_ready),
		.out_channel     (out_channel),
		.out_window      (out_window),
		.out_index       (out_index),
		.out_adc         (out_adc),
		.out_last        (out_last),
		.seq_error_count (seq_error_count),
		.drop_count      (drop_count)
	);

endmodule

// ==== verilog/event_packer.sv ====
`timescale 1ns/1ps

module event_packer (
	input  logic                                 sysclk,
	input  logic                                 reset,
	alpha_word_if.dst                            wi,
	input  logic                                 config_done,
	output logic                                 out_valid,
	input  logic                                 out_ready,
	output logic [alpha_pkg::CHANNEL_BITS-1:0]   out_channel,
	output logic [alpha_pkg::WINDOW_BITS-1:0]    out_window,
	output logic [alpha_pkg::INDEX_BITS-1:0]     out_index,
	output logic [alpha_pkg::ADC_BITS-1:0]       out_adc,
	output logic                                 out_last,
	output logic [alpha_pkg::COUNT_BITS-1:0]     seq_error_count,
	output logic [alpha_pkg::COUNT_BITS-1:0]     drop_count
);
	import alpha_pkg::*;

	logic                        in_packet;
	logic [CHANNEL_BITS-1:0]     cur_channel;
	logic [WINDOW_BITS-1:0]      cur_window;
	logic [COUNT_FIELD_BITS-1:0] cur_count;
	logic [INDEX_BITS-1:0]       expect_index;

	logic [ENTRY_BITS-1:0] mem [FIFO_DEPTH];
	logic [PTR_BITS-1:0]   wr_ptr;
	logic [PTR_BITS-1:0]   rd_ptr;
	logic [PTR_BITS:0]     mem_count;

	logic is_sample, index_ok, sample_ok, last_sample;
	logic seq_fault, fifo_full, push, drop, pop;

	function automatic logic [COUNT_BITS-1:0] sat_inc(input logic [COUNT_BITS-1:0] value);
		return (&value) ? value : value + 1'b1;
	endfunction

	// ----------------------------------------
	// packet sequence check
	assign is_sample   = wi.valid && !wi.framing_error && !wi.header;
	assign index_ok    = wi.word.smp.index == expect_index;
	assign sample_ok   = is_sample && in_packet && index_ok;
	assign last_sample = wi.word.smp.index == INDEX_BITS'(cur_count);
	assign seq_fault   = wi.valid && (wi.framing_error || (wi.header && in_packet)
		|| (is_sample && !(in_packet && index_ok)));

	// occupancy includes the output register
	assign fifo_full = (mem_count + (PTR_BITS+1)'(out_valid)) == (PTR_BITS+1)'(FIFO_DEPTH);
	assign push      = sample_ok && config_done && !fifo_full;
	assign drop      = sample_ok && !(config_done && !fifo_full);
	assign pop       = (mem_count != '0) && (!out_valid || out_ready);

	always_ff @(posedge sysclk) begin
		if (reset) begin
			in_packet       <= 1'b0;
			expect_index    <= '0;
			seq_error_count <= '0;
			drop_count      <= '0;
		end else begin
			if (seq_fault) seq_error_count <= sat_inc(seq_error_count);
			if (drop) drop_count <= sat_inc(drop_count);
			if (wi.valid) begin
				if (wi.framing_error) begin
					in_packet <= 1'b0;
				end else if (wi.header) begin // restarts even mid-packet
					in_packet    <= 1'b1;
					expect_index <= '0;
				end else if (sample_ok && !last_sample) begin
					expect_index <= expect_index + 1'b1;
				end else begin
					in_packet <= 1'b0; // last sample or bad index
				end
			end
		end
	end

	always_ff @(posedge sysclk) begin
		if (wi.valid && wi.header && !wi.framing_error) begin
			cur_channel <= wi.word.hdr.channel;
			cur_window  <= wi.word.hdr.window;
			cur_count   <= wi.word.hdr.count;
		end
	end

	// ----------------------------------------
	// output fifo, registered head
	always_ff @(posedge sysclk) begin
		if (push) begin
			mem[wr_ptr] <= {cur_channel, cur_window, wi.word.smp.index, wi.word.smp.adc,
				last_sample};
		end
	end

	always_ff @(posedge sysclk) begin
		if (reset) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			mem_count <= '0;
			out_valid <= 1'b0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			mem_count <= mem_count + (PTR_BITS+1)'(push) - (PTR_BITS+1)'(pop);
			if (pop) begin
				out_valid <= 1'b1;
			end else if (out_ready) begin
				out_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge sysclk) begin
		if (pop) begin
			{out_channel, out_window, out_index, out_adc, out_last} <= mem[rd_ptr];
		end
	end

endmodule

// ==== verilog/alpha_readout.sv ====
`timescale 1ns/1ps

module alpha_readout (
	input  logic     sysclk,
	input  logic     reset,
	input  logic     data_a,
	alpha_word_if.src wo
);
	import alpha_pkg::*;

	// frame on data_a: start 1, WORD_BITS msb first, stop 0
	// one bit per sysclk, line idles low

	logic                   busy;
	logic [RX_CNT_BITS-1:0] bit_cnt;
	logic [WORD_BITS-1:0]   shreg;
	logic                   at_stop;
	logic                   is_header;

	assign at_stop   = bit_cnt == RX_CNT_BITS'(WORD_BITS);
	assign is_header = shreg[WORD_BITS-1 -: MARK_BITS] == HEADER_MARK;

	// ----------------------------------------
	// frame control
	always_ff @(posedge sysclk) begin
		if (reset) begin
			busy     <= 1'b0;
			bit_cnt  <= '0;
			wo.valid <= 1'b0;
		end else begin
			wo.valid <= 1'b0;
			if (!busy) begin
				if (data_a) begin // start bit
					busy    <= 1'b1;
					bit_cnt <= '0;
				end
			end else if (at_stop) begin
				busy     <= 1'b0; // ready for a start bit next edge
				wo.valid <= 1'b1;
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	// ----------------------------------------
	// payload path
	always_ff @(posedge sysclk) begin
		if (busy && !at_stop) begin
			shreg <= {shreg[WORD_BITS-2:0], data_a};
		end
	end

	always_ff @(posedge sysclk) begin
		if (busy && at_stop) begin
			wo.word          <= shreg;
			wo.header        <= is_header;
			wo.framing_error <= data_a; // stop must be low
		end
	end

endmodule

// ==== verilog/bias_programmer.sv ====
`timescale 1ns/1ps

module bias_programmer (
	input  logic                           sysclk,
	input  logic                           reset,
	input  logic                           cfg_valid,
	output logic                           cfg_ready,
	input  logic [alpha_pkg::BIAS_BITS-1:0] cmp_bias,
	input  logic [alpha_pkg::BIAS_BITS-1:0] isel,
	input  logic [alpha_pkg::BIAS_BITS-1:0] sb_bias,
	input  logic [alpha_pkg::BIAS_BITS-1:0] db_bias,
	output logic                           sin,
	output logic                           sclk,
	output logic                           pclk,
	output logic                           config_done
);
	import alpha_pkg::*;

	logic [1:0]                 state;
	logic [BIAS_TOTAL_BITS-1:0] shreg;
	logic [DIV_BITS-1:0]        div_cnt;
	logic [BIT_CNT_BITS-1:0]    bit_cnt;
	logic [WAIT_BITS-1:0]       wait_cnt;
	logic                       accept;
	logic                       div_wrap;
	logic                       bit_done;
	logic                       last_bit;

	assign accept   = cfg_valid && cfg_ready;
	assign div_wrap = div_cnt == DIV_BITS'(SCLK_HALF - 1);
	assign bit_done = (state == BP_SHIFT) && div_wrap && sclk; // sclk about to fall
	assign last_bit = bit_cnt == BIT_CNT_BITS'(BIAS_TOTAL_BITS - 1);

	// settings word, first bit out at the top
	always_ff @(posedge sysclk) begin
		if (accept) begin
			shreg <= {cmp_bias, isel, sb_bias, db_bias};
		end else if (bit_done) begin
			shreg <= shreg << 1;
		end
	end

	// ----------------------------------------
	always_ff @(posedge sysclk) begin
		if (reset) begin
			state       <= BP_IDLE;
			cfg_ready   <= 1'b1;
			config_done <= 1'b0;
			sin         <= 1'b0;
			sclk        <= 1'b0;
			pclk        <= 1'b0;
			div_cnt     <= '0;
			bit_cnt     <= '0;
			wait_cnt    <= '0;
		end else begin
			case (state)
				BP_IDLE: begin
					if (accept) begin
						cfg_ready <= 1'b0;
						sin       <= cmp_bias[BIAS_BITS-1];
						div_cnt   <= '0;
						bit_cnt   <= '0;
						state     <= BP_SHIFT;
					end
				end
				BP_SHIFT: begin
					if (div_wrap) begin
						div_cnt <= '0;
						sclk    <= ~sclk;
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
					if (bit_done) begin
						if (last_bit) begin
							sin      <= 1'b0;
							pclk     <= 1'b1; // same edge as the last sclk fall
							wait_cnt <= '0;
							state    <= BP_LATCH;
						end else begin
							sin     <= shreg[BIAS_TOTAL_BITS-2];
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				BP_LATCH: begin
					if (wait_cnt == WAIT_BITS'(PCLK_CYCLES - 1)) begin
						pclk     <= 1'b0;
						wait_cnt <= '0;
						state    <= BP_SETTLE;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				default: begin // settle, then hand back
					if (wait_cnt == WAIT_BITS'(SETTLE_CYCLES - 1)) begin
						cfg_ready   <= 1'b1;
						config_done <= 1'b1; // sticky until reset
						state       <= BP_IDLE;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
			endcase
		end
	end

endmodule

// ==== verilog/alpha_word_if.sv ====
`timescale 1ns/1ps

interface alpha_word_if;
	import alpha_pkg::*;

	logic        valid;         // one-cycle strobe, no back-pressure
	alpha_word_u word;
	logic        header;        // top nybble matched the header mark
	logic        framing_error; // stop bit came in as 1

	modport src (
		output valid,
		output word,
		output header,
		output framing_error
	);

	modport dst (
		input valid,
		input word,
		input header,
		input framing_error
	);

endinterface

// ==== verilog/alpha_pkg.sv ====
package alpha_pkg;

	// ----------------------------------------
	// readout word layout
	localparam int WORD_BITS        = 16;
	localparam int MARK_BITS        = 4;
	localparam int CHANNEL_BITS     = 4;
	localparam int WINDOW_BITS      = 5;
	localparam int COUNT_FIELD_BITS = 3;  // packet holds count+1 samples
	localparam int INDEX_BITS       = 4;
	localparam int ADC_BITS         = 12;
	localparam int RX_CNT_BITS      = $clog2(WORD_BITS + 1);

	localparam logic [MARK_BITS-1:0] HEADER_MARK = 4'ha; // sample indices stop at 7

	// one serial word, read as header or as sample
	typedef union packed {
		struct packed {
			logic [MARK_BITS-1:0]        mark;
			logic [CHANNEL_BITS-1:0]     channel;
			logic [WINDOW_BITS-1:0]      window;
			logic [COUNT_FIELD_BITS-1:0] count;
		} hdr;
		struct packed {
			logic [INDEX_BITS-1:0] index;
			logic [ADC_BITS-1:0]   adc;
		} smp;
	} alpha_word_u;

	// ----------------------------------------
	// bias load timing
	localparam int BIAS_BITS        = 12;
	localparam int BIAS_COUNT       = 4;   // cmp_bias, isel, sb_bias, db_bias
	localparam int BIAS_TOTAL_BITS  = BIAS_COUNT * BIAS_BITS;
	localparam int SCLK_HALF        = 2;   // sysclk cycles per sclk half period
	localparam int PCLK_CYCLES      = 4;
	localparam int BIAS_LOAD_CYCLES = 200; // acceptance to cfg_ready high
	localparam int SETTLE_CYCLES    = BIAS_LOAD_CYCLES - PCLK_CYCLES
		- BIAS_TOTAL_BITS * 2 * SCLK_HALF;
	localparam int DIV_BITS         = $clog2(SCLK_HALF + 1);
	localparam int BIT_CNT_BITS     = $clog2(BIAS_TOTAL_BITS);
	localparam int WAIT_BITS        = $clog2(PCLK_CYCLES + SETTLE_CYCLES);

	localparam logic [1:0] BP_IDLE   = 2'd0;
	localparam logic [1:0] BP_SHIFT  = 2'd1;
	localparam logic [1:0] BP_LATCH  = 2'd2;
	localparam logic [1:0] BP_SETTLE = 2'd3;

	// ----------------------------------------
	// output queue
	localparam int FIFO_DEPTH = 8;
	localparam int PTR_BITS   = $clog2(FIFO_DEPTH);
	localparam int ENTRY_BITS = CHANNEL_BITS + WINDOW_BITS + INDEX_BITS + ADC_BITS + 1;
	localparam int COUNT_BITS = 8; // error and drop counters, saturating

endpackage
